// ==== Makefile ====
# Verilator lint, build and simulation of the execute slice testbench
VERILATOR := verilator
VFLAGS    := --timing --assert --timescale 1ns/1ps
TOP       := execUnitTb
FLIST     := flist.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(OBJDIR) -o $(TOP)

# the log decides, the simulator exit code alone is not enough
sim: build
	-./$(OBJDIR)/$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== design/alu.sv ====
/*
 * Flag keeping ALU
 * computes the result and next carry, zero and sign flags per opcode,
 * both registered on execute and held until the next one
 */
`timescale 1ns/1ps

module alu (
	input  logic                        CLK,
	input  logic                        RSTb,
	input  logic [dataPkg::dataBits-1:0] A,
	input  logic [dataPkg::dataBits-1:0] B,
	input  isaPkg::aluOpT               aluOp,
	input  logic                        execute,
	output logic [dataPkg::dataBits-1:0] aluOut,
	output logic                        C, /* carry or borrow */
	output logic                        Z, /* zero */
	output logic                        S  /* sign */
);

	import isaPkg::*;
	import dataPkg::*;

	logic                carryIn;  /* held C for adc and sbb */
	logic [dataBits:0]   sumFull;  /* sum with carry out */
	logic [dataBits:0]   diffFull; /* difference with borrow out */
	logic [dataBits-1:0] andRes;
	logic [dataBits-1:0] orRes;
	logic [dataBits-1:0] xorRes;
	logic [dataBits-1:0] asrRes;
	logic [dataBits-1:0] lsrRes;
	logic [dataBits-1:0] lslRes;
	logic [dataBits-1:0] aluRes;   /* next result */
	logic                cNext;
	logic                zNext;
	logic                sNext;

	assign carryIn = ((aluOp == aluAdc) || (aluOp == aluSbb)) ? C : 1'b0;

	/* shared adder and subtractor, cmp uses the subtractor too */
	assign sumFull  = {1'b0, A} + {1'b0, B} + {{dataBits{1'b0}}, carryIn};
	assign diffFull = {1'b0, A} - {1'b0, B} - {{dataBits{1'b0}}, carryIn};

	assign andRes = A & B;
	assign orRes  = A | B;
	assign xorRes = A ^ B;

	/* one bit shifts of b */
	assign asrRes = {B[dataBits-1], B[dataBits-1:1]}; /* keep sign */
	assign lsrRes = {1'b0, B[dataBits-1:1]};
	assign lslRes = {B[dataBits-2:0], 1'b0};

	always_comb begin
		aluRes = '0;  /* reserved codes give zero */
		cNext  = C;   /* flags hold unless the op sets them */
		zNext  = Z;
		sNext  = S;

		case (aluOp)
			aluMove: begin
				aluRes = B; /* flags untouched */
			end
			aluAdd, aluAdc: begin
				aluRes = sumFull[dataBits-1:0];
				cNext  = sumFull[dataBits]; /* carry out */
				zNext  = (sumFull[dataBits-1:0] == '0);
				sNext  = sumFull[dataBits-1];
			end
			aluSub, aluSbb: begin
				aluRes = diffFull[dataBits-1:0];
				cNext  = diffFull[dataBits]; /* borrow out */
				zNext  = (diffFull[dataBits-1:0] == '0);
				sNext  = diffFull[dataBits-1];
			end
			aluAnd: begin
				aluRes = andRes;
				cNext  = 1'b0;
				zNext  = (andRes == '0);
				sNext  = andRes[dataBits-1];
			end
			aluOr: begin
				aluRes = orRes;
				cNext  = 1'b0;
				zNext  = (orRes == '0);
				sNext  = orRes[dataBits-1];
			end
			aluXor: begin
				aluRes = xorRes;
				cNext  = 1'b0;
				zNext  = (xorRes == '0);
				sNext  = xorRes[dataBits-1];
			end
			aluCmp: begin
				aluRes = A; /* subtract for flags only */
				cNext  = diffFull[dataBits];
				zNext  = (diffFull[dataBits-1:0] == '0);
				sNext  = diffFull[dataBits-1];
			end
			aluTest: begin
				aluRes = A;
				zNext  = (andRes == '0); /* only Z */
			end
			aluAsr: begin
				aluRes = asrRes;
				zNext  = (asrRes == '0);
			end
			aluLsr: begin
				aluRes = lsrRes;
				zNext  = (lsrRes == '0);
			end
			aluLsl: begin
				aluRes = lslRes;
				zNext  = (lslRes == '0);
			end
			default: begin
				aluRes = '0; /* reserved */
			end
		endcase
	end

	/* result and flags update only on an issued instruction */
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			aluOut <= '0;
			C      <= 1'b0;
			Z      <= 1'b0;
			S      <= 1'b0;
		end else if (execute) begin
			aluOut <= aluRes;
			C      <= cNext;
			Z      <= zNext;
			S      <= sNext;
		end
	end

endmodule

// ==== design/dataPkg.sv ====
/*
 * Datapath package
 * operand width and register file geometry
 */
package dataPkg;

	localparam int dataBits = 16; /* operand and result width */

	localparam int regCount = 8; /* general registers r0..r7 */

	localparam int regIdxBits = $clog2(regCount); /* 3 bit reg index */

endpackage

// ==== design/execUnit.sv ====
/*
 * Execute slice top
 * decode, register file read, ALU with flags and writeback,
 * one instruction per strobe with a one cycle result latency
 */
`timescale 1ns/1ps

module execUnit (
	input  logic                          CLK,
	input  logic                          RSTb,
	input  logic                          instrValid,
	input  logic [isaPkg::instrBits-1:0]  instr,
	input  logic [dataPkg::dataBits-1:0]   imm,
	output logic                          resultValid,
	output logic [dataPkg::regIdxBits-1:0] resultReg,
	output logic [dataPkg::dataBits-1:0]   result,
	output logic                          C,
	output logic                          Z,
	output logic                          S
);

	import isaPkg::*;
	import dataPkg::*;

	aluOpT                 aluOp;
	logic [regIdxBits-1:0] rd;
	logic [regIdxBits-1:0] ra;
	logic [regIdxBits-1:0] rb;
	logic                  useImm;
	logic                  wbEn;
	logic [dataBits-1:0]   rdA;
	logic [dataBits-1:0]   rdB;
	logic [dataBits-1:0]   opB;    /* selected operand b */
	logic [dataBits-1:0]   aluOut;
	logic                  we;     /* regfile write from writeback */
	logic [regIdxBits-1:0] wa;
	logic [dataBits-1:0]   wd;

	instrDecode decode0 (
		.instr(instr), .aluOp(aluOp), .rd(rd), .ra(ra), .rb(rb),
		.useImm(useImm), .wbEn(wbEn)
	);

	regFile regFile0 (
		.CLK(CLK), .RSTb(RSTb), .ra(ra), .rb(rb), .rdA(rdA), .rdB(rdB),
		.we(we), .wa(wa), .wd(wd)
	);

	assign opB = useImm ? imm : rdB; /* immediate or register */

	alu alu0 (
		.CLK(CLK), .RSTb(RSTb), .A(rdA), .B(opB), .aluOp(aluOp),
		.execute(instrValid), .aluOut(aluOut), .C(C), .Z(Z), .S(S)
	);

	writeback wb0 (
		.CLK(CLK), .RSTb(RSTb), .issue(instrValid), .wbEn(wbEn), .rd(rd),
		.aluOut(aluOut), .resultValid(resultValid), .resultReg(resultReg),
		.result(result), .we(we), .wa(wa), .wd(wd)
	);

endmodule

// ==== design/instrDecode.sv ====
/*
 * Instruction decoder
 * splits the packed word into opcode and register fields,
 * picks the operand b source and flags ops that write a register
 */
`timescale 1ns/1ps

module instrDecode (
	input  logic [isaPkg::instrBits-1:0]  instr,
	output isaPkg::aluOpT                 aluOp,
	output logic [dataPkg::regIdxBits-1:0] rd,
	output logic [dataPkg::regIdxBits-1:0] ra,
	output logic [dataPkg::regIdxBits-1:0] rb,
	output logic                          useImm,
	output logic                          wbEn
);

	import isaPkg::*;
	import dataPkg::*;

	/* opcode, reserved codes stay as raw values */
	assign aluOp = aluOpT'(instr[opLsb +: opBits]);

	/* register fields */
	assign rd = instr[rdLsb +: regIdxBits]; /* destination */
	assign ra = instr[raLsb +: regIdxBits]; /* operand a */
	assign rb = instr[rbLsb +: regIdxBits]; /* operand b when no imm */

	assign useImm = instr[useImmBit]; /* imm replaces rb */

	/* which ops write back to the register file */
	always_comb begin
		case (aluOp)
			/* move and arithmetic */
			aluMove,
			aluAdd,
			aluAdc,
			aluSub,
			aluSbb: begin
				wbEn = 1'b1;
			end
			/* bitwise logic */
			aluAnd,
			aluOr,
			aluXor: begin
				wbEn = 1'b1;
			end
			/* shifts */
			aluAsr,
			aluLsr,
			aluLsl: begin
				wbEn = 1'b1;
			end
			/* cmp and test touch flags only */
			aluCmp,
			aluTest: begin
				wbEn = 1'b0;
			end
			default: begin
				wbEn = 1'b0; /* reserved, no write */
			end
		endcase
	end

endmodule

// ==== design/isaPkg.sv ====
/*
 * ISA package for the execute slice
 * instruction word layout, opcode values and the ALU op enum
 */
package isaPkg;

	localparam int instrBits = 16; /* packed instruction word */
	localparam int opBits    = 5;  /* opcode field width */

	/* field positions, lsb of each field */
	localparam int opLsb     = 11; /* opcode in bits 15..11 */
	localparam int rdLsb     = 8;  /* destination reg in 10..8 */
	localparam int raLsb     = 5;  /* source a in 7..5 */
	localparam int rbLsb     = 2;  /* source b in 4..2 */
	localparam int useImmBit = 1;  /* operand b from imm */
	/* bit 0 reserved */

	/* arithmetic */
	localparam logic [opBits-1:0] opMove = 5'd0;
	localparam logic [opBits-1:0] opAdd  = 5'd1;
	localparam logic [opBits-1:0] opAdc  = 5'd2;  /* add with carry */
	localparam logic [opBits-1:0] opSub  = 5'd3;
	localparam logic [opBits-1:0] opSbb  = 5'd4;  /* sub with borrow */
	/* logic */
	localparam logic [opBits-1:0] opAnd  = 5'd5;
	localparam logic [opBits-1:0] opOr   = 5'd6;
	localparam logic [opBits-1:0] opXor  = 5'd7;
	/* flag only */
	localparam logic [opBits-1:0] opCmp  = 5'd12;
	localparam logic [opBits-1:0] opTest = 5'd13;
	/* single bit shifts on b */
	localparam logic [opBits-1:0] opAsr  = 5'd16;
	localparam logic [opBits-1:0] opLsr  = 5'd17;
	localparam logic [opBits-1:0] opLsl  = 5'd18;

	/* named ALU ops, any other code is reserved */
	typedef enum logic [opBits-1:0] {
		aluMove = opMove,
		aluAdd  = opAdd,
		aluAdc  = opAdc,
		aluSub  = opSub,
		aluSbb  = opSbb,
		aluAnd  = opAnd,
		aluOr   = opOr,
		aluXor  = opXor,
		aluCmp  = opCmp,
		aluTest = opTest,
		aluAsr  = opAsr,
		aluLsr  = opLsr,
		aluLsl  = opLsl
	} aluOpT;

endpackage

// ==== design/regFile.sv ====
/*
 * Register file
 * eight general registers, two combinational read ports, one write
 * port and a bypass that forwards the write data to a matching read
 */
`timescale 1ns/1ps

module regFile (
	input  logic                          CLK,
	input  logic                          RSTb,
	input  logic [dataPkg::regIdxBits-1:0] ra,
	input  logic [dataPkg::regIdxBits-1:0] rb,
	output logic [dataPkg::dataBits-1:0]   rdA,
	output logic [dataPkg::dataBits-1:0]   rdB,
	input  logic                          we,
	input  logic [dataPkg::regIdxBits-1:0] wa,
	input  logic [dataPkg::dataBits-1:0]   wd
);

	import dataPkg::*;

	logic [dataBits-1:0] regs [regCount]; /* storage */

	logic bypassA; /* write hits port a */
	logic bypassB; /* write hits port b */

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0; /* all regs zero after reset */
			end
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

	/* a write in this cycle lands at the edge, forward it now */
	assign bypassA = we && (wa == ra);
	assign bypassB = we && (wa == rb);

	assign rdA = bypassA ? wd : regs[ra];
	assign rdB = bypassB ? wd : regs[rb];

endmodule

// ==== design/writeback.sv ====
/*
 * Writeback stage
 * holds destination and write decision for one cycle, then raises
 * the result strobe and drives the register file write port
 */
`timescale 1ns/1ps

module writeback (
	input  logic                          CLK,
	input  logic                          RSTb,
	input  logic                          issue,
	input  logic                          wbEn,
	input  logic [dataPkg::regIdxBits-1:0] rd,
	input  logic [dataPkg::dataBits-1:0]   aluOut,
	output logic                          resultValid,
	output logic [dataPkg::regIdxBits-1:0] resultReg,
	output logic [dataPkg::dataBits-1:0]   result,
	output logic                          we,
	output logic [dataPkg::regIdxBits-1:0] wa,
	output logic [dataPkg::dataBits-1:0]   wd
);

	import dataPkg::*;

	logic                  issueQ; /* instruction at execute last cycle */
	logic                  wbEnQ;  /* it writes a register */
	logic [regIdxBits-1:0] rdQ;    /* its destination */

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			issueQ <= 1'b0;
			wbEnQ  <= 1'b0;
			rdQ    <= '0;
		end else begin
			issueQ <= issue;
			wbEnQ  <= issue & wbEn; /* no write without a strobe */
			rdQ    <= rd;
		end
	end

	/* completion strobe for every op, cmp and test too */
	assign resultValid = issueQ;
	assign resultReg   = rdQ;
	assign result      = aluOut; /* registered in the ALU */

	/* register write, lands at the end of this cycle */
	assign we = wbEnQ;
	assign wa = rdQ;
	assign wd = aluOut;

endmodule

// ==== dv/execModel.svh ====
/*
 * Reference model of the execute slice
 * register and flag state, plus a predictor for one instruction
 */
`ifndef execModelSvh
`define execModelSvh

logic [dataBits-1:0] modelReg [regCount]; /* expected register contents */
logic                modelC; /* flags after the last instruction */
logic                modelZ;
logic                modelS;

function automatic void modelReset();
	for (int i = 0; i < regCount; i++) begin
		modelReg[i] = '0;
	end
	modelC = 1'b0;
	modelZ = 1'b0;
	modelS = 1'b0;
endfunction

function automatic void setZeroSign(input logic [dataBits-1:0] v);
	modelZ = (v == '0);
	modelS = v[dataBits-1]; /* msb is the sign */
endfunction

/* applies one instruction to the model and returns its result */
function automatic void predict(input logic [opBits-1:0] op,
		input logic [regIdxBits-1:0] rd, input logic [regIdxBits-1:0] ra,
		input logic [regIdxBits-1:0] rb, input logic useImm,
		input logic [dataBits-1:0] immVal, output logic [dataBits-1:0] res);
	logic [dataBits-1:0] a;
	logic [dataBits-1:0] b;
	logic                writes;
	int                  wide; /* exact sum or difference */
	int                  cin;
	a = modelReg[ra];
	b = useImm ? immVal : modelReg[rb];
	res = '0; /* reserved codes give zero */
	writes = 1'b0;
	case (op)
		opMove: begin
			res = b; /* flags stay */
			writes = 1'b1;
		end
		opAdd, opAdc: begin
			cin = (op == opAdc) ? int'(modelC) : 0;
			wide = int'(a) + int'(b) + cin;
			res = wide[dataBits-1:0];
			modelC = wide[dataBits]; /* carry past bit 15 */
			setZeroSign(res);
			writes = 1'b1;
		end
		opSub, opSbb: begin
			cin = (op == opSbb) ? int'(modelC) : 0;
			wide = int'(a) - int'(b) - cin;
			res = wide[dataBits-1:0];
			modelC = (wide < 0); /* borrow when it goes negative */
			setZeroSign(res);
			writes = 1'b1;
		end
		opAnd, opOr, opXor: begin
			res = (op == opAnd) ? (a & b) : (op == opOr) ? (a | b) : (a ^ b);
			modelC = 1'b0;
			setZeroSign(res);
			writes = 1'b1;
		end
		opCmp: begin
			wide = int'(a) - int'(b);
			modelC = (wide < 0);
			setZeroSign(wide[dataBits-1:0]);
			res = a;
		end
		opTest: begin
			modelZ = ((a & b) == '0); /* only Z moves */
			res = a;
		end
		opAsr, opLsr, opLsl: begin
			res = (op == opLsl) ? (b << 1) : {(op == opAsr) & b[dataBits-1], b[dataBits-1:1]};
			modelZ = (res == '0);
			writes = 1'b1;
		end
		default: begin
			res = '0; /* reserved, flags kept */
		end
	endcase
	if (writes) begin
		modelReg[rd] = res;
	end
endfunction

`endif

// ==== dv/execUnitTb.sv ====
/*
 * Testbench for the execute slice
 * directed tests of load, arithmetic, logic, shifts, compare and
 * back to back dependent instructions, checked against a model
 */
`timescale 1ns/1ps

module execUnitTb;

	import isaPkg::*;
	import dataPkg::*;

	localparam int resetCycles = 16;
	localparam int waitLimit   = 20; /* cycles before a wait gives up */
	localparam int chainLen    = 12;

	logic                  CLK;
	logic                  RSTb;
	logic                  instrValid;
	logic [instrBits-1:0]  instr;
	logic [dataBits-1:0]   imm;
	logic                  resultValid;
	logic [regIdxBits-1:0] resultReg;
	logic [dataBits-1:0]   result;
	logic                  C;
	logic                  Z;
	logic                  S;
	integer                seed;

	`include "execModel.svh"

	execUnit dut0 (
		.CLK(CLK), .RSTb(RSTb), .instrValid(instrValid), .instr(instr), .imm(imm),
		.resultValid(resultValid), .resultReg(resultReg), .result(result),
		.C(C), .Z(Z), .S(S)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK; /* 4 ns period */
	end

	task automatic abortRun();
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkValue(input string name, input logic [dataBits-1:0] got,
			input logic [dataBits-1:0] exp);
		assert (got === exp) else begin
			$display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkExpect(input logic [regIdxBits-1:0] rd,
			input logic [dataBits-1:0] res, input logic c, input logic z, input logic s);
		checkValue("resultReg", dataBits'(resultReg), dataBits'(rd));
		checkValue("result", result, res);
		checkValue("C", dataBits'(C), dataBits'(c));
		checkValue("Z", dataBits'(Z), dataBits'(z));
		checkValue("S", dataBits'(S), dataBits'(s));
	endtask

	function automatic logic [dataBits-1:0] randWord();
		logic [31:0] r;
		r = $random(seed);
		return r[dataBits-1:0];
	endfunction

	function automatic logic [instrBits-1:0] encode(input logic [opBits-1:0] op,
			input logic [regIdxBits-1:0] rd, input logic [regIdxBits-1:0] ra,
			input logic [regIdxBits-1:0] rb, input logic useImm);
		logic [instrBits-1:0] w;
		w = '0; /* reserved bit 0 stays low */
		w[opLsb +: opBits] = op;
		w[rdLsb +: regIdxBits] = rd;
		w[raLsb +: regIdxBits] = ra;
		w[rbLsb +: regIdxBits] = rb;
		w[useImmBit] = useImm;
		return w;
	endfunction

	/* one strobe, then wait for its result and check it */
	task automatic runOp(input logic [opBits-1:0] op, input logic [regIdxBits-1:0] rd,
			input logic [regIdxBits-1:0] ra, input logic [regIdxBits-1:0] rb,
			input logic useImm, input logic [dataBits-1:0] immVal);
		logic [dataBits-1:0] expRes;
		int                  cycles;
		predict(op, rd, ra, rb, useImm, immVal, expRes);
		@(posedge CLK);
		instrValid <= 1'b1;
		instr      <= encode(op, rd, ra, rb, useImm);
		imm        <= immVal;
		@(negedge CLK);
		checkValue("resultValid", dataBits'(resultValid), '0); /* not yet */
		@(posedge CLK);
		instrValid <= 1'b0;
		cycles = 1;
		@(negedge CLK);
		while (!resultValid && cycles < waitLimit) begin
			cycles++;
			@(negedge CLK);
		end
		if (!resultValid) begin
			$display("Timeout: resultValid never rose for opcode %h", op);
			abortRun();
		end
		checkValue("latency", dataBits'(cycles), dataBits'(1));
		checkExpect(rd, expRes, modelC, modelZ, modelS);
	endtask

	task automatic loadPair(input logic [dataBits-1:0] a, input logic [dataBits-1:0] b);
		runOp(opMove, 3'd1, 3'd0, 3'd0, 1'b1, a);
		runOp(opMove, 3'd2, 3'd0, 3'd0, 1'b1, b);
	endtask

	task automatic testResetLoad();
		@(negedge CLK);
		checkValue("resultValid", dataBits'(resultValid), '0);
		checkExpect(3'd0, '0, 1'b0, 1'b0, 1'b0); /* everything clear */
		for (int r = 0; r < regCount; r++) begin
			runOp(opMove, regIdxBits'(r), 3'd0, 3'd0, 1'b1, randWord());
		end
	endtask

	task automatic arithSet(input logic [dataBits-1:0] k);
		runOp(opAdd, 3'd3, 3'd1, 3'd2, 1'b0, '0);
		runOp(opAdc, 3'd4, 3'd1, 3'd2, 1'b0, '0); /* carry left by add */
		runOp(opSub, 3'd5, 3'd1, 3'd2, 1'b0, '0);
		runOp(opSbb, 3'd6, 3'd1, 3'd2, 1'b0, '0); /* borrow left by sub */
		runOp(opAdc, 3'd7, 3'd1, 3'd0, 1'b1, k);
		runOp(opSbb, 3'd7, 3'd7, 3'd0, 1'b1, k);
	endtask

	task automatic testArith();
		logic [dataBits-1:0] edges [5];
		edges = '{16'h0000, 16'hFFFF, 16'h8000, 16'h0001, 16'h7FFF};
		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 5; j++) begin
				loadPair(edges[i], edges[j]);
				arithSet(edges[j]);
			end
		end
		repeat (8) begin
			loadPair(randWord(), randWord());
			arithSet(randWord());
		end
	endtask

	task automatic testLogicShift();
		logic [dataBits-1:0] v;
		repeat (6) begin
			loadPair(randWord(), randWord());
			runOp(opAnd, 3'd3, 3'd1, 3'd2, 1'b0, '0);
			runOp(opOr, 3'd4, 3'd1, 3'd2, 1'b0, '0);
			runOp(opXor, 3'd5, 3'd1, 3'd1, 1'b0, '0); /* self xor is zero */
			runOp(opSub, 3'd6, 3'd5, 3'd0, 1'b1, 16'h0001); /* C and S high */
			v = randWord();
			runOp(opAsr, 3'd3, 3'd0, 3'd0, 1'b1, v);
			runOp(opLsr, 3'd3, 3'd0, 3'd0, 1'b1, v);
			runOp(opLsl, 3'd3, 3'd0, 3'd0, 1'b1, v);
			runOp(opLsr, 3'd3, 3'd0, 3'd0, 1'b1, 16'h0001); /* shifts out to zero */
			runOp(opAsr, 3'd4, 3'd0, 3'd2, 1'b0, '0);
		end
	endtask

	task automatic testCompare();
		logic [dataBits-1:0] v;
		repeat (4) begin
			v = randWord();
			loadPair(v, randWord());
			runOp(opMove, 3'd5, 3'd0, 3'd0, 1'b1, 16'h5a5a); /* must survive */
			runOp(opCmp, 3'd5, 3'd1, 3'd2, 1'b0, '0);
			runOp(opCmp, 3'd5, 3'd1, 3'd0, 1'b1, v); /* equal operands */
			runOp(opCmp, 3'd5, 3'd5, 3'd0, 1'b1, 16'hC000); /* C and S high for test */
			runOp(opTest, 3'd5, 3'd1, 3'd2, 1'b0, '0);
			runOp(opTest, 3'd5, 3'd1, 3'd0, 1'b1, ~v); /* disjoint bits */
			runOp(opSub, 3'd7, 3'd2, 3'd1, 1'b0, '0);
			runOp(5'd9, 3'd5, 3'd1, 3'd2, 1'b0, '0); /* reserved codes */
			runOp(5'd23, 3'd5, 3'd1, 3'd2, 1'b0, '0);
			runOp(opMove, 3'd6, 3'd0, 3'd5, 1'b0, '0);
			checkValue("result", result, 16'h5a5a);
		end
	endtask

	/* consecutive strobes, each reading the previous destination */
	task automatic testChain();
		logic [opBits-1:0]     ops [8];
		logic [dataBits-1:0]   expRes [chainLen];
		logic [regIdxBits-1:0] expRd [chainLen];
		logic [2:0]            expFlags [chainLen]; /* C, Z, S */
		logic [regIdxBits-1:0] prev;
		logic [dataBits-1:0]   r;
		ops = '{opAdd, opAdc, opSub, opXor, opLsl, opSbb, opOr, opAsr};
		prev = 3'd1;
		for (int i = 0; i <= chainLen; i++) begin
			@(posedge CLK);
			if (i < chainLen) begin
				r = randWord(); /* rb, useImm and imm from one word */
				expRd[i] = regIdxBits'((i + 2) % regCount);
				predict(ops[i % 8], expRd[i], prev, r[4:2], r[15], r, expRes[i]);
				expFlags[i] = {modelC, modelZ, modelS};
				instrValid <= 1'b1;
				instr      <= encode(ops[i % 8], expRd[i], prev, r[4:2], r[15]);
				imm        <= r;
				prev = expRd[i];
			end else begin
				instrValid <= 1'b0;
			end
			@(negedge CLK);
			if (i > 0) begin
				checkValue("resultValid", dataBits'(resultValid), dataBits'(1));
				checkExpect(expRd[i-1], expRes[i-1], expFlags[i-1][2], expFlags[i-1][1],
					expFlags[i-1][0]);
			end
		end
	endtask

	initial begin
		seed       = 32'h4a52_2632;
		RSTb       = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		imm        = '0;
		modelReset();
		repeat (resetCycles) @(posedge CLK);
		RSTb <= 1'b1;
		testResetLoad();
		testArith();
		testLogicShift();
		testCompare();
		testChain();
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== flist.f ====
design/dataPkg.sv
design/isaPkg.sv
design/instrDecode.sv
design/regFile.sv
design/alu.sv
design/writeback.sv
design/execUnit.sv
+incdir+dv
dv/execUnitTb.sv
